// File: filelist.f
+incdir+test
verilog/cpuControlPkg.sv
verilog/statusRegister.sv
verilog/interruptSync.sv
verilog/controlSequencer.sv
verilog/controlDecode.sv
verilog/cpuControl.sv
test/cpuControlTb.sv

// File: Bender.yml
package:
  name: cpuControl

sources:
  - files:
      - verilog/cpuControlPkg.sv
      - verilog/statusRegister.sv
      - verilog/interruptSync.sv
      - verilog/controlSequencer.sv
      - verilog/controlDecode.sv
      - verilog/cpuControl.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/cpuControlTb.sv

// File: test/cpuControlChecks.svh
// Reference functions for the expected control words and the typed compare tasks
`ifndef CPU_CONTROL_CHECKS_SVH
`define CPU_CONTROL_CHECKS_SVH

// ALU function of each arithmetic and logic instruction
function automatic aluFn_t refAluOp(opcode_t op);
   case (op)
      ADD, ADDI, ADDIB:            return FnADD;
      ADC, ADCI, SUC, SUCI:        return FnADC;   // Carry-in forms
      SUB, SUBI, SUBIB, CMP, CMPI: return FnSUB;
      NEG:                         return FnNEG;
      AND:                         return FnAND;
      OR:                          return FnOR;
      XOR:                         return FnXOR;
      NOT:                         return FnNOT;
      NAND:                        return FnNAND;
      NOR:                         return FnNOR;
      LSL:                         return FnLSL;
      LSR:                         return FnLSR;
      ASR:                         return FnASR;
      LUI:                         return FnLUI;
      LLI:                         return FnLLI;
      default:                     return FnA;
   endcase
endfunction

function automatic logic refRegWe(opcode_t op);
   return !(op inside {CMP, CMPI});   // Compares only set flags
endfunction

function automatic logic refWritesFlags(opcode_t op);
   return (op inside {[ADD:LLI]}) && !(op inside {LUI, LLI});   // Load-immediate keeps flags
endfunction

// Next-PC choice of a branch from the stored flags
function automatic pcSel_t refBranchPc(branch_t code, flags_t f);
   logic lessThan;
   lessThan = f[FlagN] ^ f[FlagV];
   case (code)
      RET:     return PcSysbus;
      JMP:     return PcAluOut;
      BNE:     return f[FlagZ] ? Pc1 : PcAluOut;
      BE:      return f[FlagZ] ? PcAluOut : Pc1;
      BLT:     return lessThan ? PcAluOut : Pc1;
      BGE:     return lessThan ? Pc1 : PcAluOut;
      default: return PcAluOut;   // BR and BWL always jump
   endcase
endfunction

function automatic int refExecCycles(opcode_t op, intCode_t code);
   if ((op inside {LDW, STW}) || ((op == INTERRUPT) && (code == IntReti))) begin
      return 5;
   end
   return 1;
endfunction

task automatic compareDatapath(string name, datapathCtrl_t got, datapathCtrl_t exp,
                               datapathCtrl_t care);
   if (((got ^ exp) & care) !== '0) begin
      failRun($sformatf("Mismatch %s: got %h expected %h", name, got & care, exp & care));
   end
endtask

task automatic compareMemory(string name, memCtrl_t got, memCtrl_t exp, memCtrl_t care);
   if (((got ^ exp) & care) !== '0) begin
      failRun($sformatf("Mismatch %s: got %h expected %h", name, got & care, exp & care));
   end
endtask

task automatic compareWord(string name, word_t got, word_t exp);
   if (got !== exp) begin
      failRun($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
   end
endtask

task automatic compareBit(string name, logic got, logic exp);
   if (got !== exp) begin
      failRun($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
   end
endtask

`endif

// File: test/cpuControlTb.sv
`timescale 1ns/1ps
// Testbench with clock, reset, LFSR instruction driver, DUT, scoreboard and timeout
module cpuControlTb import cpuControlPkg::*; ();

   localparam int NumInstructions = 400;
   localparam int MaxCycles       = NumInstructions * 12;
   localparam int ResetCycles     = 16;
   localparam logic [31:0] Seed   = 32'h535c_0a46;

   typedef struct packed {
      datapathCtrl_t Dp;
      datapathCtrl_t DpCare;   // Ones mark checked fields
      memCtrl_t      Mem;
      memCtrl_t      MemCare;
      logic          Drive;
      logic          BusCheck;
      word_t         Bus;
      logic          CFlag;
   } cycleExp_t;

   logic          Clock;
   logic          nReset;
   logic [7:0]    OpcodeCondIn;
   flags_t        Flags;
   word_t         SysBusIn;
   logic          nWait;
   logic          nIRQ;
   datapathCtrl_t Datapath;
   memCtrl_t      Memory;
   logic          CFlag;
   word_t         SysBusOut;
   logic          SysBusDrive;

   cycleExp_t   expQueue[$];
   logic [31:0] lfsr;
   flags_t      storedFlags;   // Status register model
   logic        intEnabled;
   int          cycleCount = 0;

   task automatic failRun(string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopped at the first error");
   endtask

   `include "cpuControlChecks.svh"

   function automatic logic [31:0] lfsrStep(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [7:0] randomBits(int n);
      logic [7:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsrStep(lfsr);
         r    = {r[6:0], lfsr[0]};
      end
      return r;
   endfunction

   // Write enables are low unless a cycle expects otherwise
   function automatic cycleExp_t blankExp();
      cycleExp_t e;
      e              = '0;
      e.DpCare.RegWe = 1'b1;
      e.DpCare.IrWe  = 1'b1;
      e.DpCare.LrWe  = 1'b1;
      e.CFlag        = storedFlags[FlagC];
      return e;
   endfunction

   function automatic cycleExp_t fetchExp(subCycle_t c);
      cycleExp_t e;
      e             = blankExp();
      e.MemCare.ALE = 1'b1;
      e.MemCare.nME = 1'b1;
      e.Mem.ALE     = (c == Cycle0);                  // Address latch
      e.Mem.nME     = !(c inside {Cycle1, Cycle2});   // Memory read window
      e.Dp.IrWe     = (c == Cycle3);
      return e;
   endfunction

   function automatic cycleExp_t execExp(opcode_t op, logic [2:0] code, subCycle_t c);
      cycleExp_t e;
      e = blankExp();
      if (op inside {[ADD:LLI]}) begin
         if (c == Cycle0) begin
            e.DpCare.AluOp = aluFn_t'(4'hF);
            e.DpCare.PcSel = pcSel_t'(2'h3);
            e.Dp.AluOp     = refAluOp(op);
            e.Dp.RegWe     = refRegWe(op);
            e.Dp.PcSel     = Pc1;
         end
      end else if (op == BRANCH) begin
         e.DpCare.PcSel = pcSel_t'(2'h3);
         e.DpCare.PcWe  = 1'b1;
         e.Dp.PcSel     = refBranchPc(branch_t'(code), storedFlags);
         e.Dp.PcWe      = 1'b1;
         if (branch_t'(code) == BWL) begin
            e.DpCare.LrSel = lrSel_t'(1'b1);
            e.Dp.LrSel     = LrPc;   // Return address into the link register
            e.Dp.LrWe      = 1'b1;
         end
      end else if ((op == LDW) && (c == Cycle4)) begin
         e.DpCare.WdSel = wdSel_t'(1'b1);
         e.Dp.WdSel     = WdSys;
         e.Dp.RegWe     = 1'b1;
      end else if (op == INTERRUPT) begin
         if (intCode_t'(code) == IntSave) begin
            e.Drive    = 1'b1;
            e.BusCheck = 1'b1;
            e.Bus      = word_t'(storedFlags);
         end else if ((intCode_t'(code) == IntReti) && (c == Cycle4)) begin
            e.DpCare.PcSel = pcSel_t'(2'h3);
            e.Dp.PcSel     = PcSysbus;
         end
      end
      return e;
   endfunction

   function automatic cycleExp_t interruptExp(subCycle_t c);
      cycleExp_t e;
      e              = blankExp();
      e.DpCare.PcWe  = 1'b1;
      e.Dp.PcWe      = (c == Cycle4);
      e.MemCare.ALE  = (c == Cycle0);   // Tells the sequence apart from a fetch
      if (c == Cycle4) begin
         e.DpCare.PcSel = pcSel_t'(2'h3);
         e.Dp.PcSel     = PcInt;
      end
      return e;
   endfunction

   task automatic nextCycle();
      @(posedge Clock);
      #1;
   endtask

   task automatic chooseInstruction(output opcode_t op, output logic [2:0] code);
      logic [2:0] kind;
      kind = 3'(randomBits(3));
      code = 3'(randomBits(3));
      if (kind < 3'd2) begin
         op   = INTERRUPT;
         code = 3'(code % 3'd5);
      end else if (kind == 3'd2) begin
         op = BRANCH;
      end else if (kind == 3'd3) begin
         op = randomBits(1) ? STW : LDW;
      end else begin
         op = opcode_t'(5'(randomBits(5) % 8'd24));   // ALU group
      end
   endtask

   task automatic updateModel(opcode_t op, logic [2:0] code, flags_t newFlags, word_t busIn);
      if (refWritesFlags(op)) begin
         storedFlags = newFlags;
      end
      if (op == INTERRUPT) begin
         case (intCode_t'(code))
            IntRestore: storedFlags = busIn[3:0];
            IntEnable:  intEnabled  = 1'b1;
            IntDisable: intEnabled  = 1'b0;
            default:    ;
         endcase
      end
   endtask

   task automatic runInstruction();
      opcode_t    op;
      logic [2:0] code;
      flags_t     newFlags;
      word_t      busIn;
      logic       pulse;
      logic       takeIrq;
      int         waits;
      int         execCycles;
      pulse   = (randomBits(2) == 8'd0);
      takeIrq = pulse && intEnabled;   // Request seen before the instruction ends
      nIRQ    = !pulse;
      expQueue.push_back(fetchExp(Cycle0));
      nextCycle();
      nIRQ = 1'b1;
      expQueue.push_back(fetchExp(Cycle1));
      nextCycle();
      waits = int'(randomBits(2));
      for (int i = 0; i <= waits; i++) begin
         nWait = (i == waits);
         expQueue.push_back(fetchExp(Cycle2));
         nextCycle();
      end
      chooseInstruction(op, code);
      newFlags        = 4'(randomBits(4));
      busIn[15:8]     = randomBits(8);
      busIn[7:0]      = randomBits(8);
      OpcodeCondIn    = {op, code};   // Instruction register loads here
      Flags           = newFlags;
      SysBusIn        = busIn;
      expQueue.push_back(fetchExp(Cycle3));
      nextCycle();
      execCycles = refExecCycles(op, intCode_t'(code));
      for (int c = 0; c < execCycles; c++) begin
         waits = (c == 3) ? int'(randomBits(2)) : 0;
         for (int i = 0; i <= waits; i++) begin
            nWait = (i == waits);
            expQueue.push_back(execExp(op, code, subCycle_t'(3'(c))));
            nextCycle();
         end
         if (c == 0) begin
            updateModel(op, code, newFlags, busIn);
         end
      end
      if (takeIrq) begin
         for (int c = 0; c < 5; c++) begin
            expQueue.push_back(interruptExp(subCycle_t'(3'(c))));
            nextCycle();
         end
      end
   endtask

   cpuControl i_cpuControl (
      .Clock        (Clock),
      .nReset       (nReset),
      .OpcodeCondIn (OpcodeCondIn),
      .Flags        (Flags),
      .SysBusIn     (SysBusIn),
      .nWait        (nWait),
      .nIRQ         (nIRQ),
      .Datapath     (Datapath),
      .Memory       (Memory),
      .CFlag        (CFlag),
      .SysBusOut    (SysBusOut),
      .SysBusDrive  (SysBusDrive)
   );

   initial begin
      Clock = 1'b0;
      forever #4 Clock = ~Clock;
   end

   always @(posedge Clock) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= MaxCycles) begin
         failRun($sformatf("Timeout after %0d cycles, instruction stream unfinished",
                           cycleCount));
      end
   end

   // Outputs settle well before the falling edge
   initial begin : scoreboard
      cycleExp_t e;
      forever begin
         @(negedge Clock);
         if (expQueue.size() > 0) begin
            e = expQueue.pop_front();
            compareDatapath("Datapath", Datapath, e.Dp, e.DpCare);
            compareMemory("Memory", Memory, e.Mem, e.MemCare);
            compareBit("SysBusDrive", SysBusDrive, e.Drive);
            if (e.BusCheck) begin
               compareWord("SysBusOut", SysBusOut, e.Bus);
            end
            compareBit("CFlag", CFlag, e.CFlag);
         end
      end
   end

   initial begin : driver
      nReset       = 1'b0;
      OpcodeCondIn = '0;
      Flags        = '0;
      SysBusIn     = '0;
      nWait        = 1'b1;
      nIRQ         = 1'b1;
      lfsr         = Seed;
      storedFlags  = '0;
      intEnabled   = 1'b0;
      repeat (ResetCycles) @(posedge Clock);
      #1;
      nReset = 1'b1;   // First fetch cycle starts now
      for (int n = 0; n < NumInstructions; n++) begin
         runInstruction();
      end
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// File: verilog/cpuControl.sv
`timescale 1ns/1ps
// Control unit top with opcode split, sequencer, decoder, status register and interrupt logic
module cpuControl import cpuControlPkg::*; (
   input  logic          Clock,
   input  logic          nReset,
   input  logic [7:0]    OpcodeCondIn,
   input  flags_t        Flags,
   input  word_t         SysBusIn,
   input  logic          nWait,
   input  logic          nIRQ,
   output datapathCtrl_t Datapath,
   output memCtrl_t      Memory,
   output logic          CFlag,
   output word_t         SysBusOut,
   output logic          SysBusDrive
);

   opcode_t     Opcode;
   branch_t     BranchCode;
   intCode_t    IntCode;
   phase_t      Phase;
   subCycle_t   SubCycle;
   flags_t      StatusFlags;
   statusCtrl_t StatusCtrl;
   intCtrl_t    IntCtrl;
   logic        IntReq;
   logic        EnterIsr;

   assign Opcode     = opcode_t'(OpcodeCondIn[7:3]);
   assign BranchCode = branch_t'(OpcodeCondIn[2:0]);    // Condition field
   assign IntCode    = intCode_t'(OpcodeCondIn[2:0]);   // Same field for INTERRUPT
   assign CFlag      = StatusFlags[FlagC];

   controlSequencer i_controlSequencer (
      .Clock    (Clock),
      .nReset   (nReset),
      .Opcode   (Opcode),
      .IntCode  (IntCode),
      .nWait    (nWait),
      .IntReq   (IntReq),
      .Phase    (Phase),
      .SubCycle (SubCycle),
      .EnterIsr (EnterIsr)
   );

   controlDecode i_controlDecode (
      .Phase       (Phase),
      .SubCycle    (SubCycle),
      .Opcode      (Opcode),
      .BranchCode  (BranchCode),
      .IntCode     (IntCode),
      .StatusFlags (StatusFlags),
      .Datapath    (Datapath),
      .Memory      (Memory),
      .StatusCtrl  (StatusCtrl),
      .IntCtrl     (IntCtrl)
   );

   statusRegister i_statusRegister (
      .Clock       (Clock),
      .nReset      (nReset),
      .StatusCtrl  (StatusCtrl),
      .Flags       (Flags),
      .SysBusIn    (SysBusIn),
      .StatusFlags (StatusFlags),
      .SysBusOut   (SysBusOut),
      .SysBusDrive (SysBusDrive)
   );

   interruptSync i_interruptSync (
      .Clock    (Clock),
      .nReset   (nReset),
      .nIRQ     (nIRQ),
      .IntCtrl  (IntCtrl),
      .EnterIsr (EnterIsr),
      .IntReq   (IntReq)
   );

endmodule

// File: verilog/controlDecode.sv
`timescale 1ns/1ps
// Control word decoder for fetch, execute and interrupt cycles
module controlDecode import cpuControlPkg::*; (
   input  phase_t        Phase,
   input  subCycle_t     SubCycle,
   input  opcode_t       Opcode,
   input  branch_t       BranchCode,
   input  intCode_t      IntCode,
   input  flags_t        StatusFlags,
   output datapathCtrl_t Datapath,
   output memCtrl_t      Memory,
   output statusCtrl_t   StatusCtrl,
   output intCtrl_t      IntCtrl
);

   aluFn_t AluFunction;
   logic   SignedLess;
   logic   BranchTaken;
   logic   UsesRd2;
   logic   UsesShortImm;
   logic   UsesRdSource;
   logic   LoadsImm;

   assign SignedLess   = StatusFlags[FlagN] ^ StatusFlags[FlagV];
   assign UsesRd2      = Opcode inside {ADD, SUB, CMP, AND, OR, XOR, NAND, NOR};
   assign UsesShortImm = Opcode inside {ADDI, ADCI, SUBI, SUCI, CMPI, LSL, LSR, ASR};
   assign UsesRdSource = Opcode inside {ADDIB, SUBIB, LUI, LLI};   // Byte and load-immediate
   assign LoadsImm     = Opcode inside {LUI, LLI};

   always_comb begin
      case (BranchCode)
         BR, BWL: BranchTaken = 1'b1;
         BNE:     BranchTaken = !StatusFlags[FlagZ];
         BE:      BranchTaken = StatusFlags[FlagZ];
         BLT:     BranchTaken = SignedLess;
         BGE:     BranchTaken = !SignedLess;
         default: BranchTaken = 1'b0;
      endcase
   end

   always_comb begin
      case (Opcode)
         ADD, ADDI, ADDIB:            AluFunction = FnADD;
         ADC, ADCI, SUC, SUCI:        AluFunction = FnADC;
         SUB, SUBI, SUBIB, CMP, CMPI: AluFunction = FnSUB;
         NEG:                         AluFunction = FnNEG;
         AND:                         AluFunction = FnAND;
         OR:                          AluFunction = FnOR;
         XOR:                         AluFunction = FnXOR;
         NOT:                         AluFunction = FnNOT;
         NAND:                        AluFunction = FnNAND;
         NOR:                         AluFunction = FnNOR;
         LSL:                         AluFunction = FnLSL;
         LSR:                         AluFunction = FnLSR;
         ASR:                         AluFunction = FnASR;
         LUI:                         AluFunction = FnLUI;
         LLI:                         AluFunction = FnLLI;
         default:                     AluFunction = FnA;
      endcase
   end

   always_comb begin
      Datapath   = DatapathIdle;
      Memory     = MemoryIdle;
      StatusCtrl = '0;
      IntCtrl    = '0;
      case (Phase)
         Fetch: begin
            Memory.nWE = 1'b1;   // Read only
            case (SubCycle)
               Cycle0: begin
                  Memory.ALE    = 1'b1;
                  Memory.nOE    = 1'b1;
                  Datapath.PcEn = 1'b1;   // PC is the address
               end
               Cycle1: begin
                  Memory.nME   = 1'b0;
                  Memory.MemEn = 1'b1;
               end
               Cycle2: begin
                  Memory.nME   = 1'b0;
                  Memory.MemEn = 1'b1;
                  Memory.ENB   = 1'b1;
               end
               default: begin
                  Memory.MemEn  = 1'b1;
                  Datapath.IrWe = 1'b1;
               end
            endcase
         end
         Execute: begin
            case (SubCycle)
               Cycle0: begin
                  case (Opcode)
                     LDW, STW: begin   // Effective address Rd1 + offset
                        Datapath.AluOp  = FnADD;
                        Datapath.ImmSel = ImmShort;
                        Datapath.AluEn  = 1'b1;
                        Datapath.AluWe  = 1'b1;
                     end
                     BRANCH: begin
                        Datapath.PcWe = 1'b1;
                        case (BranchCode)
                           RET: begin
                              Datapath.LrEn  = 1'b1;
                              Datapath.PcSel = PcSysbus;
                           end
                           JMP: begin
                              Datapath.AluOp  = FnADD;
                              Datapath.ImmSel = ImmShort;
                              Datapath.PcSel  = PcAluOut;
                           end
                           default: begin   // PC-relative
                              Datapath.AluOp  = FnADD;
                              Datapath.Op1Sel = Op1Pc;
                              Datapath.AluEn  = 1'b1;
                              if (BranchTaken) begin
                                 Datapath.PcSel = PcAluOut;
                                 Datapath.LrWe  = (BranchCode == BWL);
                                 Datapath.LrSel = (BranchCode == BWL) ? LrPc : LrSys;
                              end
                           end
                        endcase
                     end
                     INTERRUPT: begin
                        case (IntCode)
                           IntReti: begin   // Stack pointer into the ALU register
                              Datapath.Rs1Sel = Rs1Sp;
                              Datapath.AluEn  = 1'b1;
                              Datapath.AluWe  = 1'b1;
                           end
                           IntSave: begin
                              Datapath.PcWe    = 1'b1;
                              StatusCtrl.Drive = 1'b1;
                           end
                           IntRestore: begin
                              Datapath.PcWe      = 1'b1;
                              StatusCtrl.Restore = 1'b1;
                           end
                           default: begin
                              Datapath.PcWe   = 1'b1;
                              Datapath.PcEn   = 1'b1;
                              IntCtrl.Enable  = (IntCode == IntEnable);
                              IntCtrl.Disable = (IntCode == IntDisable);
                           end
                        endcase
                     end
                     default: begin   // Single-cycle ALU group
                        Datapath.AluOp   = AluFunction;
                        Datapath.Op2Sel  = UsesRd2 ? Op2Rd2 : Op2Imm;
                        Datapath.ImmSel  = UsesShortImm ? ImmShort : ImmLong;
                        Datapath.Rs1Sel  = UsesRdSource ? Rs1Rd : Rs1Ra;
                        Datapath.RegWe   = !(Opcode inside {CMP, CMPI});
                        Datapath.PcWe    = 1'b1;
                        Datapath.AluEn   = LoadsImm;
                        Datapath.PcEn    = !LoadsImm;
                        StatusCtrl.Write = !LoadsImm;
                     end
                  endcase
               end
               Cycle1: begin   // Address strobe
                  Memory.ALE     = 1'b1;
                  Memory.nWE     = 1'b1;
                  Memory.nOE     = 1'b1;
                  Datapath.AluEn = 1'b1;
                  if (Opcode == INTERRUPT) begin
                     Datapath.Rs1Sel = Rs1Sp;
                  end else begin
                     Datapath.AluOp  = FnADD;
                     Datapath.ImmSel = ImmShort;
                  end
               end
               Cycle2: begin
                  Memory.nME     = 1'b0;
                  Memory.nWE     = 1'b1;
                  Datapath.AluEn = 1'b1;
                  Datapath.AluWe = 1'b1;
                  if (Opcode == INTERRUPT) begin
                     Datapath.Rs1Sel = Rs1Sp;
                     Memory.MemEn    = 1'b1;
                  end else begin
                     Datapath.Rs1Sel = Rs1Rd;   // Store data passes through the ALU
                     Memory.nOE      = 1'b1;
                     Memory.MemEn    = (Opcode == LDW);
                  end
               end
               Cycle3: begin   // Data phase, held by nWait
                  Memory.nME = 1'b0;
                  if (Opcode == STW) begin
                     Datapath.AluEn = 1'b1;
                     Memory.nOE     = 1'b1;
                  end else begin
                     Memory.MemEn = 1'b1;
                     Memory.ENB   = 1'b1;
                     Memory.nWE   = 1'b1;
                  end
               end
               default: begin
                  Datapath.PcWe = 1'b1;
                  if (Opcode == STW) begin
                     Datapath.AluEn = 1'b1;
                     Memory.nOE     = 1'b1;
                  end else begin
                     Memory.MemEn = 1'b1;
                     Memory.nWE   = 1'b1;
                     if (Opcode == LDW) begin
                        Datapath.WdSel = WdSys;
                        Datapath.RegWe = 1'b1;
                     end else begin
                        Datapath.PcSel   = PcSysbus;   // Return address from the stack
                        IntCtrl.LeaveIsr = 1'b1;
                     end
                  end
               end
            endcase
         end
         Interrupt: begin
            case (SubCycle)
               Cycle0: begin
                  Datapath.Rs1Sel = Rs1Sp;
                  Datapath.AluEn  = 1'b1;
                  Datapath.AluWe  = 1'b1;
               end
               Cycle1: begin
                  Datapath.Rs1Sel = Rs1Sp;
                  Datapath.AluEn  = 1'b1;
                  Memory.ALE      = 1'b1;
                  Memory.nWE      = 1'b1;
                  Memory.nOE      = 1'b1;
               end
               Cycle2: begin
                  Datapath.AluEn = 1'b1;
                  Memory.nME     = 1'b0;
                  Memory.nOE     = 1'b1;
                  Memory.nWE     = 1'b1;
               end
               Cycle3: begin   // PC written to the stack
                  Datapath.PcEn = 1'b1;
                  Memory.nME    = 1'b0;
                  Memory.nOE    = 1'b1;
               end
               default: begin
                  Datapath.PcEn  = 1'b1;
                  Datapath.PcSel = PcInt;
                  Datapath.PcWe  = 1'b1;
                  Memory.nOE     = 1'b1;
                  IntCtrl.Clear  = 1'b1;
               end
            endcase
         end
         default: begin
            Datapath = DatapathIdle;
         end
      endcase
   end

endmodule

// File: verilog/controlSequencer.sv
`timescale 1ns/1ps
// Phase and sub-cycle FSM with wait-state stalls and interrupt entry
module controlSequencer import cpuControlPkg::*; (
   input  logic      Clock,
   input  logic      nReset,
   input  opcode_t   Opcode,
   input  intCode_t  IntCode,
   input  logic      nWait,
   input  logic      IntReq,
   output phase_t    Phase,
   output subCycle_t SubCycle,
   output logic      EnterIsr
);

   logic LongExecute;   // Five execute cycles
   logic Stall;
   logic LastCycle;

   assign LongExecute = (Opcode == LDW) || (Opcode == STW) ||
                        ((Opcode == INTERRUPT) && (IntCode == IntReti));

   // Memory data cycles wait for nWait
   assign Stall = !nWait && (((Phase == Fetch) && (SubCycle == Cycle2)) ||
                             ((Phase == Execute) && (SubCycle == Cycle3)));

   always_comb begin
      case (Phase)
         Fetch:     LastCycle = (SubCycle == Cycle3);
         Execute:   LastCycle = (SubCycle == Cycle4) ||
                                ((SubCycle == Cycle0) && !LongExecute);
         default:   LastCycle = (SubCycle == Cycle4);
      endcase
   end

   assign EnterIsr = (Phase == Interrupt) && (SubCycle == Cycle0);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         Phase    <= Fetch;
         SubCycle <= Cycle0;
      end else if (!Stall) begin
         if (LastCycle) begin
            SubCycle <= Cycle0;
            case (Phase)
               Fetch:   Phase <= Execute;
               Execute: Phase <= IntReq ? Interrupt : Fetch;   // Take a pending request
               default: Phase <= Fetch;
            endcase
         end else begin
            SubCycle <= subCycle_t'(SubCycle + 3'd1);
         end
      end
   end

endmodule

// File: verilog/interruptSync.sv
`timescale 1ns/1ps
// nIRQ synchroniser with pending request, enable flag and in-service flag
module interruptSync import cpuControlPkg::*; (
   input  logic     Clock,
   input  logic     nReset,
   input  logic     nIRQ,
   input  intCtrl_t IntCtrl,
   input  logic     EnterIsr,
   output logic     IntReq
);

   logic IrqMeta;      // First stage, active high
   logic IrqSync;      // Second stage
   logic IntEnabled;
   logic InService;
   logic NewRequest;

   // A fresh edge may nest, a held level waits until the handler has returned
   assign NewRequest = IntEnabled && ((IrqMeta && !IrqSync) || (IrqSync && !InService));

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         IrqMeta    <= 1'b0;
         IrqSync    <= 1'b0;
         IntReq     <= 1'b0;
         IntEnabled <= 1'b0;
         InService  <= 1'b0;
      end else begin
         IrqMeta <= !nIRQ;
         IrqSync <= IrqMeta;
         IntReq  <= NewRequest || (IntReq && !IntCtrl.Clear);
         if (IntCtrl.Enable) begin
            IntEnabled <= 1'b1;
         end else if (IntCtrl.Disable) begin
            IntEnabled <= 1'b0;
         end
         if (EnterIsr) begin
            InService <= 1'b1;
         end else if (IntCtrl.LeaveIsr) begin
            InService <= 1'b0;   // End of RETI
         end
      end
   end

endmodule

// File: verilog/statusRegister.sv
`timescale 1ns/1ps
// Status flag register with save to and restore from the system bus
module statusRegister import cpuControlPkg::*; (
   input  logic        Clock,
   input  logic        nReset,
   input  statusCtrl_t StatusCtrl,
   input  flags_t      Flags,
   input  word_t       SysBusIn,
   output flags_t      StatusFlags,
   output word_t       SysBusOut,
   output logic        SysBusDrive
);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         StatusFlags <= '0;
      end else if (StatusCtrl.Restore) begin
         StatusFlags <= SysBusIn[3:0];   // Saved word from the bus
      end else if (StatusCtrl.Write) begin
         StatusFlags <= Flags;           // Fresh ALU flags
      end
   end

   assign SysBusDrive = StatusCtrl.Drive;
   assign SysBusOut   = StatusCtrl.Drive ? word_t'(StatusFlags) : '0;   // Zero-extended

endmodule

// File: verilog/cpuControlPkg.sv
// Bus and flag types, opcode, branch, select and state enums, control word structs
package cpuControlPkg;

   typedef logic [15:0] word_t;    // System bus word
   typedef logic [3:0]  flags_t;   // Condition flags

   localparam int FlagC = 0;   // Carry
   localparam int FlagZ = 1;   // Zero
   localparam int FlagN = 2;   // Negative
   localparam int FlagV = 3;   // Overflow

   typedef enum logic [4:0] {
      ADD    = 5'd0,  ADDI   = 5'd1,  ADDIB  = 5'd2,  ADC    = 5'd3,
      ADCI   = 5'd4,  SUB    = 5'd5,  SUBI   = 5'd6,  SUBIB  = 5'd7,
      SUC    = 5'd8,  SUCI   = 5'd9,  CMP    = 5'd10, CMPI   = 5'd11,
      AND    = 5'd12, OR     = 5'd13, XOR    = 5'd14, NOT    = 5'd15,
      NAND   = 5'd16, NOR    = 5'd17, NEG    = 5'd18, LSL    = 5'd19,
      LSR    = 5'd20, ASR    = 5'd21, LUI    = 5'd22, LLI    = 5'd23,
      LDW    = 5'd24, STW    = 5'd25, BRANCH = 5'd26, INTERRUPT = 5'd27
   } opcode_t;

   typedef enum logic [2:0] {
      BR, BNE, BE, BLT, BGE, BWL, RET, JMP
   } branch_t;

   typedef enum logic [2:0] {
      IntReti    = 3'd0,
      IntEnable  = 3'd1,
      IntDisable = 3'd2,
      IntSave    = 3'd3,   // Flags onto the system bus
      IntRestore = 3'd4    // Flags from the system bus
   } intCode_t;

   typedef enum logic [3:0] {
      FnA, FnADD, FnADC, FnSUB, FnNEG, FnAND, FnOR, FnXOR,
      FnNOT, FnNAND, FnNOR, FnLSL, FnLSR, FnASR, FnLUI, FnLLI
   } aluFn_t;

   typedef enum logic       {Op1Rd1, Op1Pc} op1Sel_t;
   typedef enum logic       {Op2Imm, Op2Rd2} op2Sel_t;
   typedef enum logic       {ImmLong, ImmShort} immSel_t;
   typedef enum logic       {WdAlu, WdSys} wdSel_t;
   typedef enum logic [1:0] {Rs1Ra, Rs1Rd, Rs1Sp} rs1Sel_t;
   typedef enum logic       {RwRd} rwSel_t;
   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus, PcInt} pcSel_t;
   typedef enum logic       {LrSys, LrPc} lrSel_t;

   typedef enum logic [1:0] {Fetch, Execute, Interrupt} phase_t;
   typedef enum logic [2:0] {Cycle0, Cycle1, Cycle2, Cycle3, Cycle4} subCycle_t;

   typedef struct packed {
      aluFn_t  AluOp;
      op1Sel_t Op1Sel;
      op2Sel_t Op2Sel;
      immSel_t ImmSel;
      wdSel_t  WdSel;
      rs1Sel_t Rs1Sel;
      rwSel_t  RwSel;
      pcSel_t  PcSel;
      lrSel_t  LrSel;
      logic    AluEn;    // ALU result onto the system bus
      logic    AluWe;
      logic    RegWe;
      logic    PcWe;
      logic    PcEn;     // PC onto the system bus
      logic    IrWe;
      logic    LrEn;     // Link register onto the system bus
      logic    LrWe;
   } datapathCtrl_t;

   typedef struct packed {
      logic MemEn;   // Pad direction
      logic nWE;
      logic nOE;
      logic nME;
      logic ENB;
      logic ALE;
   } memCtrl_t;

   typedef struct packed {
      logic Write;
      logic Drive;
      logic Restore;
   } statusCtrl_t;

   typedef struct packed {
      logic Clear;
      logic Enable;
      logic Disable;
      logic LeaveIsr;
   } intCtrl_t;

   localparam datapathCtrl_t DatapathIdle = '{
      AluOp: FnA, Op1Sel: Op1Rd1, Op2Sel: Op2Imm, ImmSel: ImmLong,
      WdSel: WdAlu, Rs1Sel: Rs1Ra, RwSel: RwRd, PcSel: Pc1, LrSel: LrSys,
      AluEn: 1'b0, AluWe: 1'b0, RegWe: 1'b0, PcWe: 1'b0,
      PcEn: 1'b0, IrWe: 1'b0, LrEn: 1'b0, LrWe: 1'b0
   };

   localparam memCtrl_t MemoryIdle = '{
      MemEn: 1'b0, nWE: 1'b0, nOE: 1'b0, nME: 1'b1, ENB: 1'b0, ALE: 1'b0
   };

endpackage
